// File: Makefile
VERILATOR ?= verilator
TOP       ?= iq_loopback_tb
SEED_ARGS ?=
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f project.f
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: project.f
source/iq_types_pkg.sv
source/apb_regs_pkg.sv
source/iq_deframer.sv
source/sample_fifo.sv
source/iq_framer.sv
source/ctrl_regs.sv
source/iq_loopback_top.sv
verification/iq_loopback_tb.sv

// File: source/apb_regs_pkg.sv
`default_nettype none

package apb_regs_pkg;

  localparam int APB_ADDR_W = 8;
  localparam int APB_DATA_W = 32;

  // register offsets
  typedef enum logic [APB_ADDR_W-1:0] {
    REG_CTRL   = 8'h00,
    REG_STATUS = 8'h04,
    REG_COUNT  = 8'h08
  } reg_addr_e;

  // CTRL bits
  // bit 3 r1_mode, bit 2 enable, bit 1 txnrx, bit 0 run
  typedef struct packed {
    logic r1_mode;
    logic enable;
    logic txnrx;
    logic run;
  } ctrl_reg_t;

  // STATUS bits, sticky and write-1-to-clear
  // bit 1 frame_err, bit 0 overflow
  typedef struct packed {
    logic frame_err;
    logic overflow;
  } status_reg_t;

endpackage

`default_nettype wire

// File: source/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs import apb_regs_pkg::*; #(
  parameter int COUNT_WIDTH = 16
) (
  input  wire                    clk,
  input  wire                    rst,
  input  wire [APB_ADDR_W-1:0]   paddr,
  input  wire                    psel,
  input  wire                    penable,
  input  wire                    pwrite,
  input  wire [APB_DATA_W-1:0]   pwdata,
  output logic [APB_DATA_W-1:0]  prdata,
  output logic                   pready,
  output logic                   pslverr,
  input  wire                    sample_pulse,
  input  wire                    frame_err_pulse,
  input  wire                    overflow_pulse,
  output ctrl_reg_t              ctrl,
  output logic                   enable,
  output logic                   txnrx
);

  status_reg_t            status;
  status_reg_t            status_set;
  status_reg_t            status_clr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   access;
  logic                   addr_ok;
  logic                   wr_en;

  assign access  = psel && penable;
  assign pready  = access;
  assign pslverr = access && !addr_ok;
  assign wr_en   = access && pwrite && addr_ok;

  // offset decode and read mux
  always_comb begin
    addr_ok = 1'b1;
    prdata  = '0;
    case (paddr)
      REG_CTRL:   prdata = APB_DATA_W'(ctrl);
      REG_STATUS: prdata = APB_DATA_W'(status);
      REG_COUNT:  prdata = APB_DATA_W'(count);
      default:    addr_ok = 1'b0;
    endcase
  end

  assign status_set = {frame_err_pulse, overflow_pulse};
  assign status_clr = (wr_en && paddr == REG_STATUS) ?
                      status_reg_t'(pwdata[$bits(status_reg_t)-1:0]) : '0;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ctrl   <= '0;
      status <= '0;
      count  <= '0;
      enable <= 1'b0;
      txnrx  <= 1'b0;
    end else begin
      if (wr_en && paddr == REG_CTRL) begin
        ctrl <= ctrl_reg_t'(pwdata[$bits(ctrl_reg_t)-1:0]);
      end
      // a new event wins over a clear in the same cycle
      status <= (status & ~status_clr) | status_set;
      if (sample_pulse) begin
        count <= count + 1'b1;
      end
      enable <= ctrl.enable;
      txnrx  <= ctrl.txnrx;
    end
  end

endmodule

`default_nettype wire

// File: source/iq_deframer.sv
`timescale 1ns/1ps
`default_nettype none

module iq_deframer import iq_types_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire          run,
  input  wire          r1_mode,
  input  lane_word_t   rx_word,
  input  wire          rx_valid,
  output logic         push_valid,
  output sample_pair_t push_data,
  output logic         frame_err_pulse
);

  iq_sample_t first_q;
  logic       have_first;
  logic       take;

  // words only count while the chain runs
  assign take = run && rx_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      push_valid      <= 1'b0;
      push_data       <= '0;
      frame_err_pulse <= 1'b0;
      first_q         <= '0;
      have_first      <= 1'b0;
    end else begin
      push_valid      <= 1'b0;
      frame_err_pulse <= 1'b0;
      if (take && r1_mode) begin
        have_first <= 1'b0;
        if (rx_word.frame == FRAME_R1) begin
          push_valid     <= 1'b1;
          push_data.ch0  <= word_to_sample(rx_word);
          push_data.ch1  <= '0;
          push_data.dual <= 1'b0;
        end else begin
          frame_err_pulse <= 1'b1;
        end
      end else if (take) begin
        if (rx_word.frame == FRAME_R2_FIRST && !have_first) begin
          first_q    <= word_to_sample(rx_word);
          have_first <= 1'b1;
        end else if (rx_word.frame == FRAME_R2_SECOND && have_first) begin
          // second half completes the stored first half
          push_valid     <= 1'b1;
          push_data.ch0  <= first_q;
          push_data.ch1  <= word_to_sample(rx_word);
          push_data.dual <= 1'b1;
          have_first     <= 1'b0;
        end else begin
          // misplaced pattern drops the partial sample
          frame_err_pulse <= 1'b1;
          have_first      <= 1'b0;
        end
      end
    end
  end

  a_push_or_err: assert property (@(posedge clk) disable iff (rst)
    !(push_valid && frame_err_pulse))
    else $error("sample pushed together with a frame error");

endmodule

`default_nettype wire

// File: source/iq_framer.sv
`timescale 1ns/1ps
`default_nettype none

module iq_framer import iq_types_pkg::*; (
  input  wire          clk,
  input  wire          rst,
  input  wire          pop_valid,
  input  sample_pair_t pop_data,
  input  wire          tx_ready,
  output logic         pop_ready,
  output lane_word_t   tx_word,
  output logic         tx_valid
);

  framer_state_e state;
  iq_sample_t    ch1_q;
  logic          xfer;
  logic          to_second;
  logic          last_xfer;

  // **************************************************************************
  // handshake and entry hand-off
  // **************************************************************************

  assign tx_valid  = (state != FR_IDLE);
  assign xfer      = tx_valid && tx_ready;
  // first half of a dual entry just went out
  assign to_second = xfer && (state == FR_FIRST) && (tx_word.frame == FRAME_R2_FIRST);
  assign last_xfer = xfer && !to_second;
  // next entry only once the current one is fully sent
  assign pop_ready = pop_valid && ((state == FR_IDLE) || last_xfer);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= FR_IDLE;
    end else if (pop_ready) begin
      state <= FR_FIRST;
    end else if (to_second) begin
      state <= FR_SECOND;
    end else if (last_xfer) begin
      state <= FR_IDLE;
    end
  end

  // **************************************************************************
  // transmit word
  // **************************************************************************

  always_ff @(posedge clk) begin
    if (pop_ready) begin
      tx_word <= sample_to_word(pop_data.dual ? FRAME_R2_FIRST : FRAME_R1, pop_data.ch0);
      ch1_q   <= pop_data.ch1;
    end else if (to_second) begin
      tx_word <= sample_to_word(FRAME_R2_SECOND, ch1_q);
    end
  end

  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_word))
    else $error("tx_word changed while stalled");

endmodule

`default_nettype wire

// File: source/iq_loopback_top.sv
`timescale 1ns/1ps
`default_nettype none

module iq_loopback_top import iq_types_pkg::*, apb_regs_pkg::*; #(
  parameter int FIFO_DEPTH  = 8,
  parameter int COUNT_WIDTH = 16
) (
  input  wire                   clk,
  input  wire                   rst,
  input  wire [APB_ADDR_W-1:0]  paddr,
  input  wire                   psel,
  input  wire                   penable,
  input  wire                   pwrite,
  input  wire [APB_DATA_W-1:0]  pwdata,
  output logic [APB_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  lane_word_t            rx_word,
  input  wire                   rx_valid,
  output lane_word_t            tx_word,
  output logic                  tx_valid,
  input  wire                   tx_ready,
  output logic                  enable,
  output logic                  txnrx
);

  ctrl_reg_t    ctrl;
  logic         push_valid;
  sample_pair_t push_data;
  logic         frame_err_pulse;
  logic         overflow_pulse;
  logic         pop_valid;
  sample_pair_t pop_data;
  logic         pop_ready;

  ctrl_regs #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) ctrl_regs_inst (
    .clk             (clk),
    .rst             (rst),
    .paddr           (paddr),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .sample_pulse    (push_valid),
    .frame_err_pulse (frame_err_pulse),
    .overflow_pulse  (overflow_pulse),
    .ctrl            (ctrl),
    .enable          (enable),
    .txnrx           (txnrx)
  );

  // receive side
  iq_deframer iq_deframer_inst (
    .clk             (clk),
    .rst             (rst),
    .run             (ctrl.run),
    .r1_mode         (ctrl.r1_mode),
    .rx_word         (rx_word),
    .rx_valid        (rx_valid),
    .push_valid      (push_valid),
    .push_data       (push_data),
    .frame_err_pulse (frame_err_pulse)
  );

  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) sample_fifo_inst (
    .clk            (clk),
    .rst            (rst),
    .push_valid     (push_valid),
    .push_data      (push_data),
    .pop_ready      (pop_ready),
    .full           (),
    .pop_valid      (pop_valid),
    .pop_data       (pop_data),
    .overflow_pulse (overflow_pulse)
  );

  // transmit side
  iq_framer iq_framer_inst (
    .clk       (clk),
    .rst       (rst),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .tx_ready  (tx_ready),
    .pop_ready (pop_ready),
    .tx_word   (tx_word),
    .tx_valid  (tx_valid)
  );

endmodule

`default_nettype wire

// File: source/iq_types_pkg.sv
`default_nettype none

package iq_types_pkg;

  // frame strobe patterns carried in the 4-bit frame field
  typedef enum logic [3:0] {
    FRAME_R2_SECOND = 4'b0000,
    FRAME_R1        = 4'b1100,
    FRAME_R2_FIRST  = 4'b1111
  } frame_pat_e;

  // one parallel word: d0 i msb, d1 q msb, d2 i lsb, d3 q lsb
  typedef struct packed {
    logic [3:0] frame;
    logic [5:0] d0;
    logic [5:0] d1;
    logic [5:0] d2;
    logic [5:0] d3;
  } lane_word_t;

  typedef struct packed {
    logic [11:0] i;
    logic [11:0] q;
  } iq_sample_t;

  // buffer entry, dual set for two-channel samples
  typedef struct packed {
    iq_sample_t ch0;
    iq_sample_t ch1;
    logic       dual;
  } sample_pair_t;

  typedef enum logic [1:0] {
    FR_IDLE,
    FR_FIRST,
    FR_SECOND
  } framer_state_e;

  function automatic iq_sample_t word_to_sample(lane_word_t w);
    iq_sample_t s;
    s.i = {w.d0, w.d2};
    s.q = {w.d1, w.d3};
    return s;
  endfunction

  function automatic lane_word_t sample_to_word(frame_pat_e pat, iq_sample_t s);
    lane_word_t w;
    w.frame = pat;
    w.d0 = s.i[11:6];
    w.d1 = s.q[11:6];
    w.d2 = s.i[5:0];
    w.d3 = s.q[5:0];
    return w;
  endfunction

endpackage

`default_nettype wire

// File: source/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo import iq_types_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire          clk,
  input  wire          rst,
  input  wire          push_valid,
  input  sample_pair_t push_data,
  input  wire          pop_ready,
  output logic         full,
  output logic         pop_valid,
  output sample_pair_t pop_data,
  output logic         overflow_pulse
);

  localparam int AW = $clog2(FIFO_DEPTH);

  sample_pair_t   mem [FIFO_DEPTH];
  logic [AW:0]    wr_ptr;
  logic [AW:0]    rd_ptr;
  logic [AW:0]    fill;
  logic           wr_en;
  logic           rd_en;

  // extra pointer bit tells full from empty
  assign fill      = wr_ptr - rd_ptr;
  assign full      = (fill == (AW+1)'(FIFO_DEPTH));
  assign pop_valid = (wr_ptr != rd_ptr);
  assign pop_data  = mem[rd_ptr[AW-1:0]];
  assign wr_en     = push_valid && !full;
  assign rd_en     = pop_ready && pop_valid;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr         <= '0;
      rd_ptr         <= '0;
      overflow_pulse <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // sample lost, input side never waits
      overflow_pulse <= push_valid && full;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr[AW-1:0]] <= push_data;
    end
  end

  a_pop_needs_data: assert property (@(posedge clk) disable iff (rst)
    pop_ready |-> pop_valid)
    else $error("pop_ready while fifo empty");

  a_fill_bound: assert property (@(posedge clk) disable iff (rst)
    fill <= (AW+1)'(FIFO_DEPTH))
    else $error("fifo fill above depth");

endmodule

`default_nettype wire

// File: verification/iq_loopback_tb.sv
`timescale 1ns/1ps
`default_nettype none

module iq_loopback_tb import iq_types_pkg::*, apb_regs_pkg::*; ();

  localparam int CLK_PERIOD  = 40;
  localparam int FIFO_DEPTH  = 8;
  localparam int COUNT_WIDTH = 16;
  localparam int R1_WORDS    = 20;
  localparam int R2_PAIRS    = 12;
  localparam int OVER_WORDS  = FIFO_DEPTH + 4;
  // one entry waits in the framer on top of a full fifo
  localparam int HELD        = FIFO_DEPTH + 1;
  localparam int IDLE_WORDS  = 6;
  localparam int STIM_WORDS  = 2 * R1_WORDS + 4 * R2_PAIRS + 8 + OVER_WORDS + IDLE_WORDS;
  localparam int APB_OPS     = 24;
  localparam int WATCHDOG_NS = (STIM_WORDS * 4 + APB_OPS * 8 + 200) * CLK_PERIOD;

  logic                  clk;
  logic                  rst;
  logic [APB_ADDR_W-1:0] paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [APB_DATA_W-1:0] pwdata;
  logic [APB_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  lane_word_t            rx_word;
  logic                  rx_valid;
  lane_word_t            tx_word;
  logic                  tx_valid;
  logic                  tx_ready;
  logic                  enable;
  logic                  txnrx;

  int         seed = 32'hca318b37;
  lane_word_t exp_q[$];
  lane_word_t exp_head = '0;
  logic       exp_some = 1'b0;
  logic       xfer_seen = 1'b0;
  logic       expect_idle = 1'b0;

  iq_loopback_top #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .COUNT_WIDTH (COUNT_WIDTH)
  ) iq_loopback_top_inst (
    .clk      (clk),
    .rst      (rst),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .rx_word  (rx_word),
    .rx_valid (rx_valid),
    .tx_word  (tx_word),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .enable   (enable),
    .txnrx    (txnrx)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic fail_out(input string what);
    $display("%s", what);
    $display("FAIL: see errors above");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] got);
    a_value: assert (got === exp_v)
      else fail_out($sformatf("MISMATCH %s exp %h got %h", name, exp_v, got));
  endtask

  initial begin
    #(WATCHDOG_NS);
    fail_out("timeout: the tests did not finish in time");
  end

  // ****************************************************************************
  // scoreboard of expected transmit words
  // ****************************************************************************

  always @(posedge clk) begin
    xfer_seen <= tx_valid && tx_ready && !rst;
  end

  // queue head settles at negedge
  always @(negedge clk) begin
    if (xfer_seen && exp_q.size() != 0) begin
      void'(exp_q.pop_front());
    end
    exp_some = (exp_q.size() != 0);
    exp_head = exp_some ? exp_q[0] : '0;
  end

  a_tx_expected: assert property (@(posedge clk) disable iff (rst)
    tx_valid && tx_ready |-> exp_some)
    else fail_out("transmit word arrived with no input word waiting for it");

  a_tx_match: assert property (@(posedge clk) disable iff (rst)
    tx_valid && tx_ready && exp_some |-> tx_word == exp_head)
    else fail_out($sformatf("MISMATCH tx_word exp %h got %h",
                            $sampled(exp_head), $sampled(tx_word)));

  a_tx_hold: assert property (@(posedge clk) disable iff (rst)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_word))
    else fail_out("tx_word or tx_valid changed while tx_ready was low");

  a_no_tx_idle: assert property (@(posedge clk) disable iff (rst)
    expect_idle |-> !tx_valid)
    else fail_out("tx_valid went high while run was off");

  // ****************************************************************************
  // stimulus helpers
  // ****************************************************************************

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic apb_access(input logic [7:0] addr, input logic wr, input logic [31:0] data,
                            output logic [31:0] rd, output logic err);
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= wr;
    pwdata  <= data;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    a_pready: assert (pready === 1'b1)
      else fail_out("pready was low in an APB access phase");
    rd  = prdata;
    err = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(addr, 1'b1, data, rd, err);
    check_value("pslverr", 32'd0, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_access(addr, 1'b0, 32'd0, data, err);
    check_value("pslverr", 32'd0, err);
  endtask

  // random lanes under the given frame pattern
  // keep queues the word as an expected transmit word
  task automatic send_word(input logic [3:0] pat, input bit keep);
    logic [31:0] r;
    lane_word_t  w;
    r = $random(seed);
    w = r[27:0];
    w.frame = pat;
    @(posedge clk);
    rx_word  <= w;
    rx_valid <= 1'b1;
    if (keep) begin
      exp_q.push_back(w);
    end
  endtask

  task automatic idle_cycles(input int n);
    logic [31:0] r;
    repeat (n) begin
      r = $random(seed);
      @(posedge clk);
      rx_word  <= r[27:0];
      rx_valid <= 1'b0;
    end
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  // ****************************************************************************
  // test sequence
  // ****************************************************************************

  initial begin
    logic [31:0] rdata;
    logic [31:0] r;
    logic        rerr;
    rst      = 1'b1;
    paddr    = '0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    pwdata   = '0;
    rx_word  = '0;
    rx_valid = 1'b0;
    tx_ready = 1'b0;
    apply_reset();
    @(negedge clk);
    check_value("tx_valid", 32'd0, tx_valid);
    check_value("enable", 32'd0, enable);
    check_value("txnrx", 32'd0, txnrx);
    apb_read(REG_CTRL, rdata);
    check_value("CTRL", 32'd0, rdata);
    apb_read(REG_STATUS, rdata);
    check_value("STATUS", 32'd0, rdata);
    tx_ready <= 1'b1;

    // r1 loopback with random gaps on the input
    apb_write(REG_CTRL, 32'h9);
    for (int i = 0; i < R1_WORDS; i++) begin
      send_word(FRAME_R1, 1'b1);
      r = $random(seed);
      if (r[0]) begin
        idle_cycles(1);
      end
    end
    idle_cycles(1);
    wait_drained();

    // r2 loopback and sample count
    apb_write(REG_CTRL, 32'h1);
    for (int i = 0; i < R2_PAIRS; i++) begin
      send_word(FRAME_R2_FIRST, 1'b1);
      send_word(FRAME_R2_SECOND, 1'b1);
      r = $random(seed);
      if (r[0]) begin
        idle_cycles(1);
      end
    end
    idle_cycles(1);
    wait_drained();
    apb_read(REG_COUNT, rdata);
    check_value("COUNT", (R1_WORDS + R2_PAIRS) & ((32'd1 << COUNT_WIDTH) - 1), rdata);

    // lone second half and doubled first half
    apb_write(REG_STATUS, 32'h3);
    send_word(FRAME_R2_SECOND, 1'b0);
    idle_cycles(3);
    apb_read(REG_STATUS, rdata);
    check_value("STATUS.frame_err", 32'd1, rdata[1]);
    apb_write(REG_STATUS, 32'h2);
    apb_read(REG_STATUS, rdata);
    check_value("STATUS.frame_err", 32'd0, rdata[1]);
    send_word(FRAME_R2_FIRST, 1'b0);
    send_word(FRAME_R2_FIRST, 1'b0);
    idle_cycles(3);
    apb_read(REG_STATUS, rdata);
    check_value("STATUS.frame_err", 32'd1, rdata[1]);
    apb_write(REG_STATUS, 32'h2);
    apb_read(REG_STATUS, rdata);
    check_value("STATUS.frame_err", 32'd0, rdata[1]);
    // clean start for the back-pressure test
    apply_reset();

    // back-pressure with the overflowing tail lost
    tx_ready <= 1'b0;
    apb_write(REG_CTRL, 32'h9);
    for (int i = 0; i < OVER_WORDS; i++) begin
      send_word(FRAME_R1, i < HELD);
    end
    idle_cycles(FIFO_DEPTH);
    apb_read(REG_STATUS, rdata);
    check_value("STATUS.overflow", 32'd1, rdata[0]);
    @(negedge clk);
    check_value("tx_valid", 32'd1, tx_valid);
    @(posedge clk);
    tx_ready <= 1'b1;
    wait_drained();
    idle_cycles(4);

    // radio state outputs and bad offset with run off
    expect_idle = 1'b1;
    apb_write(REG_CTRL, 32'h4);
    @(posedge clk);
    @(negedge clk);
    check_value("enable", 32'd1, enable);
    check_value("txnrx", 32'd0, txnrx);
    apb_write(REG_CTRL, 32'hA);
    @(posedge clk);
    @(negedge clk);
    check_value("enable", 32'd0, enable);
    check_value("txnrx", 32'd1, txnrx);
    apb_access(8'h0C, 1'b0, 32'd0, rdata, rerr);
    check_value("pslverr", 32'd1, rerr);
    for (int i = 0; i < IDLE_WORDS; i++) begin
      send_word(FRAME_R1, 1'b0);
    end
    idle_cycles(8);

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire
